//--- verilog/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // ##################################################
    // Basic widths
    // ##################################################

    localparam int xlen      = 32;  // Data and address width
    localparam int reg_idx_w = 5;   // Register file index
    localparam int opcode_w  = 7;
    localparam int funct3_w  = 3;
    localparam int funct7_w  = 7;

    // Every instruction is one word, so the next sequential pc is this far ahead
    localparam logic [xlen-1:0] inst_bytes = 32'd4;

    // ##################################################
    // Field positions in the instruction word
    // ##################################################

    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // ##################################################
    // Major opcodes
    // ##################################################

    localparam logic [opcode_w-1:0] op_lui   = 7'b0110111;  // U type
    localparam logic [opcode_w-1:0] op_auipc = 7'b0010111;  // U type
    localparam logic [opcode_w-1:0] op_jal   = 7'b1101111;  // J type
    localparam logic [opcode_w-1:0] op_jalr  = 7'b1100111;  // I type
    localparam logic [opcode_w-1:0] op_br    = 7'b1100011;  // B type
    localparam logic [opcode_w-1:0] op_load  = 7'b0000011;  // I type
    localparam logic [opcode_w-1:0] op_store = 7'b0100011;  // S type
    localparam logic [opcode_w-1:0] op_imm   = 7'b0010011;  // I type
    localparam logic [opcode_w-1:0] op_reg   = 7'b0110011;  // R type

    // Register-register ops carry no immediate, the decoder still computes all five
    // and leaves the choice to the decode stage

endpackage

//--- verilog/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // ##################################################
    // Fetch configuration
    // ##################################################

    // First address fetched after reset
    localparam logic [rv32i_isa_pkg::xlen-1:0] reset_pc = 32'h6000_0000;

    // Width of the retired instruction order count
    // Anything from 32 bits up works, 64 matches the usual trace format
    localparam int order_w = 64;

    // One mask bit per byte of the instruction word
    localparam int mask_w = 4;

    // A full word read sets every byte lane
    localparam logic [mask_w-1:0] mask_full = '1;

    // No read wanted
    localparam logic [mask_w-1:0] mask_none = '0;

endpackage

//--- verilog/if_stage.sv
module if_stage #(
    parameter logic [rv32i_isa_pkg::xlen-1:0] reset_addr  = fetch_cfg_pkg::reset_pc,
    parameter int                             order_width = fetch_cfg_pkg::order_w
) (
    input  logic                              clk,
    input  logic                              rst,

    // Stall from later stages, low holds the fetch
    input  logic                              pc_en,

    // Instruction memory port
    input  logic                              imem_resp,
    output logic [rv32i_isa_pkg::xlen-1:0]    imem_addr,
    output logic [fetch_cfg_pkg::mask_w-1:0]  imem_rmask,

    // Toward the instruction register
    output logic                              load_ir,
    output logic [rv32i_isa_pkg::xlen-1:0]    fetch_pc,
    output logic [order_width-1:0]            fetch_order
);

    typedef enum logic {
        s_reset,
        s_fetching
    } state_t;

    state_t                         state;
    state_t                         next_state;
    logic [rv32i_isa_pkg::xlen-1:0] pc;
    logic [order_width-1:0]         order;

    // ##################################################
    // State and counters
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_reset;
            pc    <= reset_addr;
            order <= '0;
        end else begin
            state <= next_state;
            if (load_ir) begin  // A fetch completed on this edge
                pc    <= pc + rv32i_isa_pkg::inst_bytes;
                order <= order + order_width'(1);
            end
        end
    end

    // ##################################################
    // Fetch control
    // ##################################################

    always_comb begin
        next_state = state;
        imem_rmask = fetch_cfg_pkg::mask_none;
        load_ir    = 1'b0;
        case (state)
            s_reset: begin
                next_state = s_fetching;  // Sit out one cycle before the first request
            end
            s_fetching: begin
                imem_rmask = fetch_cfg_pkg::mask_full;
                // The memory holds its answer while stalled, so only take it with pc_en
                if (imem_resp && pc_en) begin
                    load_ir = 1'b1;
                end
            end
            default: begin
                next_state = s_reset;
            end
        endcase
    end

    // The address follows the pc and only moves when a fetch completes
    assign imem_addr = pc;

    // Pc and order of the word now being returned, not yet advanced
    assign fetch_pc    = pc;
    assign fetch_order = order;

endmodule

//--- verilog/inst_reg.sv
module inst_reg #(
    parameter int order_width = fetch_cfg_pkg::order_w
) (
    input  logic                                   clk,
    input  logic                                   rst,

    // Capture side
    input  logic                                   load_ir,
    input  logic [rv32i_isa_pkg::xlen-1:0]         in_word,
    input  logic [rv32i_isa_pkg::xlen-1:0]         in_pc,
    input  logic [order_width-1:0]                 in_order,

    // Toward decode
    output logic                                   valid,
    output logic [rv32i_isa_pkg::xlen-1:0]         inst,
    output logic [rv32i_isa_pkg::xlen-1:0]         pc,
    output logic [order_width-1:0]                 order,
    output logic [rv32i_isa_pkg::opcode_w-1:0]     opcode,
    output logic [rv32i_isa_pkg::funct3_w-1:0]     funct3,
    output logic [rv32i_isa_pkg::funct7_w-1:0]     funct7,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0]    rs1_s,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0]    rs2_s,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0]    rd_s,
    output logic [rv32i_isa_pkg::xlen-1:0]         i_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]         s_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]         b_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]         u_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]         j_imm
);

    // ##################################################
    // Capture
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            inst  <= '0;
        end else begin
            valid <= load_ir;  // High for the one cycle after a capture
            if (load_ir) begin
                inst <= in_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            pc    <= in_pc;
            order <= in_order;
        end
    end

    // ##################################################
    // Field decode
    // ##################################################

    // Register fields sit at the same place in every format
    assign opcode = inst[rv32i_isa_pkg::opcode_lsb +: rv32i_isa_pkg::opcode_w];
    assign funct3 = inst[rv32i_isa_pkg::funct3_lsb +: rv32i_isa_pkg::funct3_w];
    assign funct7 = inst[rv32i_isa_pkg::funct7_lsb +: rv32i_isa_pkg::funct7_w];
    assign rd_s   = inst[rv32i_isa_pkg::rd_lsb +: rv32i_isa_pkg::reg_idx_w];
    assign rs1_s  = inst[rv32i_isa_pkg::rs1_lsb +: rv32i_isa_pkg::reg_idx_w];
    assign rs2_s  = inst[rv32i_isa_pkg::rs2_lsb +: rv32i_isa_pkg::reg_idx_w];

    // ##################################################
    // Immediates
    // ##################################################

    // Bit 31 is always the sign, so every signed format extends from it
    assign i_imm = {{21{inst[31]}}, inst[30:20]};

    // Store splits the low five bits into the rd slot
    assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};

    // Branch offsets are in halfwords, bit 11 moved down to bit 7
    assign b_imm = {
        {20{inst[31]}},
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    assign u_imm = {inst[31:12], 12'h000};  // Upper 20 bits, low part zero

    // Jump offset, scrambled the same way the spec lays it out
    assign j_imm = {
        {12{inst[31]}},
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

endmodule

//--- verilog/fetch_top.sv
module fetch_top #(
    parameter logic [rv32i_isa_pkg::xlen-1:0] reset_addr  = fetch_cfg_pkg::reset_pc,
    parameter int                             order_width = fetch_cfg_pkg::order_w
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                pc_en,

    // Instruction memory port
    output logic [rv32i_isa_pkg::xlen-1:0]      imem_addr,
    output logic [fetch_cfg_pkg::mask_w-1:0]    imem_rmask,
    input  logic [rv32i_isa_pkg::xlen-1:0]      imem_rdata,
    input  logic                                imem_resp,

    // Toward decode
    output logic                                valid,
    output logic [rv32i_isa_pkg::xlen-1:0]      inst,
    output logic [rv32i_isa_pkg::xlen-1:0]      pc,
    output logic [order_width-1:0]              order,
    output logic [rv32i_isa_pkg::opcode_w-1:0]  opcode,
    output logic [rv32i_isa_pkg::funct3_w-1:0]  funct3,
    output logic [rv32i_isa_pkg::funct7_w-1:0]  funct7,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0] rs1_s,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0] rs2_s,
    output logic [rv32i_isa_pkg::reg_idx_w-1:0] rd_s,
    output logic [rv32i_isa_pkg::xlen-1:0]      i_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]      s_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]      b_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]      u_imm,
    output logic [rv32i_isa_pkg::xlen-1:0]      j_imm
);

    logic                           load_ir;
    logic [rv32i_isa_pkg::xlen-1:0] fetch_pc;
    logic [order_width-1:0]         fetch_order;

    if_stage #(
        .reset_addr  (reset_addr),
        .order_width (order_width)
    ) u_if_stage (
        .clk         (clk),
        .rst         (rst),
        .pc_en       (pc_en),
        .imem_resp   (imem_resp),
        .imem_addr   (imem_addr),
        .imem_rmask  (imem_rmask),
        .load_ir     (load_ir),
        .fetch_pc    (fetch_pc),
        .fetch_order (fetch_order)
    );

    // Memory data goes straight in, the fetch stage only supplies pc and order
    inst_reg #(
        .order_width (order_width)
    ) u_inst_reg (
        .clk      (clk),
        .rst      (rst),
        .load_ir  (load_ir),
        .in_word  (imem_rdata),
        .in_pc    (fetch_pc),
        .in_order (fetch_order),
        .valid    (valid),
        .inst     (inst),
        .pc       (pc),
        .order    (order),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .rs1_s    (rs1_s),
        .rs2_s    (rs2_s),
        .rd_s     (rd_s),
        .i_imm    (i_imm),
        .s_imm    (s_imm),
        .b_imm    (b_imm),
        .u_imm    (u_imm),
        .j_imm    (j_imm)
    );

endmodule

//--- verification/imem_model.sv
module imem_model (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pc_en,
    input  logic [rv32i_isa_pkg::xlen-1:0]   imem_addr,
    input  logic [fetch_cfg_pkg::mask_w-1:0] imem_rmask,
    output logic [rv32i_isa_pkg::xlen-1:0]   imem_rdata,
    output logic                             imem_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    int seed = 61;
    int delay;

    initial begin
        imem_resp  = 1'b0;
        imem_rdata = '0;
        @(negedge clk);
        forever begin
            if (rst || imem_rmask == fetch_cfg_pkg::mask_none) begin
                imem_resp = 1'b0;
                @(negedge clk);
            end else begin
                delay = $random(seed) & 3;  // Zero to three idle cycles before the answer
                repeat (delay) @(negedge clk);
                imem_resp  = 1'b1;
                imem_rdata = fetch_tb.inst_at(imem_addr);
                // The answer stays up until the fetch stage takes it
                do @(posedge clk); while (!pc_en);
                @(negedge clk);
                imem_resp = 1'b0;
            end
        end
    end

endmodule

//--- verification/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int fetches_per_test = 40;
    localparam int cycle_limit      = fetches_per_test * 5 * 8;  // Five tests, 8 cycles a fetch

    logic                                  clk;
    logic                                  rst;
    logic                                  pc_en;
    logic [rv32i_isa_pkg::xlen-1:0]        imem_addr, imem_rdata, inst, pc;
    logic [fetch_cfg_pkg::mask_w-1:0]      imem_rmask;
    logic                                  imem_resp, valid;
    logic [fetch_cfg_pkg::order_w-1:0]     order;
    logic [6:0]                            opcode, funct7;
    logic [2:0]                            funct3;
    logic [4:0]                            rs1_s, rs2_s, rd_s;
    logic [rv32i_isa_pkg::xlen-1:0]        i_imm, s_imm, b_imm, u_imm, j_imm;

    int          seed      = 61;
    int          n_pass    = 0;
    int          n_fail    = 0;
    int          n_valid   = 0;
    int          n_neg     = 0;
    int          n_holds   = 0;
    int          cycle_cnt = 0;
    logic        holding   = 1'b0;
    logic [31:0] held_addr = '0;
    logic [31:0] exp_pc    = fetch_cfg_pkg::reset_pc;
    logic [63:0] exp_order = '0;

    fetch_top u_dut (.*);
    imem_model u_imem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ##################################################
    // Memory contents and reference decode
    // ##################################################

    // One opcode class per word in turn, fields scrambled from the whole address
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        logic [31:0] h;
        logic [6:0]  op;
        h = ((addr >> 2) * 32'h9e37_79b9) ^ addr;
        h = h ^ (h >> 13);
        case ((addr >> 2) % 32'd9)
            0: op = rv32i_isa_pkg::op_lui;
            1: op = rv32i_isa_pkg::op_auipc;
            2: op = rv32i_isa_pkg::op_jal;
            3: op = rv32i_isa_pkg::op_jalr;
            4: op = rv32i_isa_pkg::op_br;
            5: op = rv32i_isa_pkg::op_load;
            6: op = rv32i_isa_pkg::op_store;
            7: op = rv32i_isa_pkg::op_imm;
            default: op = rv32i_isa_pkg::op_reg;
        endcase
        if (op == rv32i_isa_pkg::op_reg)
            return {1'b0, h[31], 5'b00000, h[24:7], op};  // funct7 is 0x00 or 0x20
        return {h[31:7], op};
    endfunction

    function automatic logic [31:0] ref_imm_i(input logic [31:0] w);
        return 32'($signed(w) >>> 20);
    endfunction

    function automatic logic [31:0] ref_imm_s(input logic [31:0] w);
        return (32'($signed(w) >>> 20) & ~32'h1f) | {27'b0, w[11:7]};
    endfunction

    function automatic logic [31:0] ref_imm_b(input logic [31:0] w);
        logic signed [12:0] off;
        off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        return 32'(off);
    endfunction

    function automatic logic [31:0] ref_imm_u(input logic [31:0] w);
        return w & 32'hffff_f000;
    endfunction

    function automatic logic [31:0] ref_imm_j(input logic [31:0] w);
        logic signed [20:0] off;
        off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        return 32'(off);
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got == exp) n_pass++;
        else begin
            n_fail++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_idle();
        compare_value("imem_rmask in reset", 64'(imem_rmask), 64'(fetch_cfg_pkg::mask_none));
        compare_value("valid in reset", 64'(valid), 64'd0);
    endtask

    // ##################################################
    // Comparing process
    // ##################################################

    always @(posedge clk) begin
        logic [31:0] w;
        if (rst) begin
            holding = 1'b0;
        end else begin
            if (holding)
                compare_value("imem_addr under stall", 64'(imem_addr), 64'(held_addr));
            holding   = imem_resp && !pc_en;
            held_addr = imem_addr;
            if (holding) n_holds++;
            if (valid) begin
                w = inst_at(exp_pc);
                compare_value("pc", 64'(pc), 64'(exp_pc));
                compare_value("order", 64'(order), exp_order);
                compare_value("inst", 64'(inst), 64'(w));
                compare_value("opcode", 64'(opcode), 64'(w[6:0]));
                compare_value("funct3", 64'(funct3), 64'(w[14:12]));
                compare_value("funct7", 64'(funct7), 64'(w[31:25]));
                compare_value("rs1_s", 64'(rs1_s), 64'(w[19:15]));
                compare_value("rs2_s", 64'(rs2_s), 64'(w[24:20]));
                compare_value("rd_s", 64'(rd_s), 64'(w[11:7]));
                compare_value("i_imm", 64'(i_imm), 64'(ref_imm_i(w)));
                compare_value("s_imm", 64'(s_imm), 64'(ref_imm_s(w)));
                compare_value("b_imm", 64'(b_imm), 64'(ref_imm_b(w)));
                compare_value("u_imm", 64'(u_imm), 64'(ref_imm_u(w)));
                compare_value("j_imm", 64'(j_imm), 64'(ref_imm_j(w)));
                if (w[31]) n_neg++;  // Sign bit set means negative immediates
                exp_pc    = exp_pc + 32'd4;
                exp_order = exp_order + 64'd1;
                n_valid++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, fetches stopped arriving", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Mode 0 plain, 1 needs negative immediates, 2 random stalls
    task automatic run_fetches(input string name, input int mode);
        int target;
        int fail_start;
        int neg_start;
        int hold_start;
        target     = n_valid + fetches_per_test;
        fail_start = n_fail;
        neg_start  = n_neg;
        hold_start = n_holds;
        while (n_valid < target) begin
            @(negedge clk);
            if (mode == 2)
                pc_en = (($random(seed) & 3) != 0);  // Low about one cycle in four
            else
                pc_en = 1'b1;
        end
        assert (mode != 1 || n_neg > neg_start) else begin
            n_fail++;
            $display("Test %s saw no instruction with a negative immediate", name);
        end
        assert (mode != 2 || n_holds > hold_start) else begin
            n_fail++;
            $display("Test %s never held a response under stall", name);
        end
        $display("Test %s finished: %0d fetches, %0d errors", name, fetches_per_test,
                 n_fail - fail_start);
    endtask

    initial begin
        rst   = 1'b1;
        pc_en = 1'b1;
        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            expect_idle();
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        expect_idle();
        @(posedge clk);
        compare_value("first imem_rmask", 64'(imem_rmask), 64'(fetch_cfg_pkg::mask_full));
        compare_value("first imem_addr", 64'(imem_addr), 64'(fetch_cfg_pkg::reset_pc));
        $display("Test reset_state finished: %0d errors", n_fail);
        run_fetches("sequential_fetch", 0);
        run_fetches("field_decode", 0);
        run_fetches("immediates", 1);
        run_fetches("stall", 2);
        $display("Summary: passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- all.f
verilog/rv32i_isa_pkg.sv
verilog/fetch_cfg_pkg.sv
verilog/if_stage.sv
verilog/inst_reg.sv
verilog/fetch_top.sv
verification/imem_model.sv
verification/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vfetch_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
